// File: verilog.f
design/lc4_pkg.sv
design/lc4_regfile.sv
design/lc4_fetch.sv
design/lc4_decode.sv
design/lc4_execute.sv
design/lc4_core.sv
test/lc4_clock.sv
test/lc4_checker.sv
test/lc4_tb.sv

// File: Makefile
# Verilator build and run for the LC4 pipeline testbench

VERILATOR ?= verilator
TOP       ?= lc4_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "all tests passed" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/lc4_tb.sv
`timescale 1ns/10ps

module lc4_tb import lc4_pkg::*; ();

  localparam int PERIOD_NS    = 4;
  localparam int RESET_CYCLES = 16;
  localparam int PROG_LEN     = 32;  // Table entries from the reset PC on
  localparam int TIMEOUT_NS   = (RESET_CYCLES + PROG_LEN + 10) * PERIOD_NS;
  localparam logic [15:0] NOP = 16'h0000;  // BR with an empty mask

  logic                 gwe;
  logic                 rst_n;
  logic [WORD_W-1:0]    cur_pc;
  logic [WORD_W-1:0]    cur_insn = NOP;
  logic                 test_valid;
  logic [WORD_W-1:0]    test_pc;
  logic                 test_regfile_we;
  logic [REG_SEL_W-1:0] test_wsel;
  logic [WORD_W-1:0]    test_wdata;
  logic                 test_nzp_we;
  logic [NZP_W-1:0]     test_nzp_bits;
  logic [WORD_W-1:0]    prog [PROG_LEN];  // Instruction memory image
  logic                 end_req   = 1'b0;
  logic                 timed_out = 1'b0;
  logic                 chk_done;
  logic                 chk_reported;
  int                   n_retired;
  int                   n_mismatch;
  int                   n_error;
  int                   n_missing;

  function automatic logic [15:0] enc_const(input logic [2:0] rd, input logic [8:0] imm9);
    return {OP_CONST, rd, imm9};
  endfunction

  function automatic logic [15:0] enc_rrr(input logic [3:0] op, input logic [2:0] rd,
                                          input logic [2:0] rs, input logic [1:0] sub,
                                          input logic [2:0] rt);
    return {op, rd, rs, 1'b0, sub, rt};
  endfunction

  function automatic logic [15:0] enc_ri(input logic [3:0] op, input logic [2:0] rd,
                                         input logic [2:0] rs, input logic [4:0] imm5);
    return {op, rd, rs, 1'b1, imm5};
  endfunction

  function automatic logic [15:0] enc_br(input logic [2:0] mask, input logic [8:0] imm9);
    return {OP_BR, mask, imm9};
  endfunction

  // Addresses outside the table read as NOP
  function automatic logic [15:0] fetch_word(input logic [15:0] pc);
    logic [15:0] off;
    off = pc - RESET_PC_DEF;
    if (off < 16'(PROG_LEN)) begin
      return prog[off[4:0]];
    end else begin
      return NOP;
    end
  endfunction

  initial begin
    for (int i = 0; i < PROG_LEN; i++) begin
      prog[i] = NOP;
    end
    prog[0]  = enc_const(3'd1, 9'd5);
    prog[1]  = enc_const(3'd2, 9'h1fd);                      // -3
    prog[2]  = enc_rrr(OP_ARITH, 3'd3, 3'd1, SUB_ADD, 3'd2); // Back-to-back on R2
    prog[3]  = enc_rrr(OP_ARITH, 3'd4, 3'd3, SUB_SUB, 3'd1);
    prog[4]  = enc_rrr(OP_ARITH, 3'd5, 3'd1, SUB_MUL, 3'd1);
    prog[5]  = enc_ri(OP_ARITH, 3'd6, 3'd5, 5'h19);         // Add -7
    prog[6]  = enc_const(3'd7, 9'h0f0);
    prog[7]  = enc_rrr(OP_LOGIC, 3'd1, 3'd7, SUB_AND, 3'd3);
    prog[8]  = enc_rrr(OP_LOGIC, 3'd2, 3'd7, SUB_OR, 3'd4);
    prog[9]  = enc_rrr(OP_LOGIC, 3'd3, 3'd7, SUB_XOR, 3'd5);
    prog[10] = enc_ri(OP_LOGIC, 3'd4, 3'd3, 5'd12);
    prog[11] = enc_ri(OP_LOGIC, 3'd5, 3'd1, 5'd0);          // Sets Z for the branch
    prog[12] = enc_br(3'b010, 9'd2);                         // BRz to index 15
    prog[13] = enc_const(3'd6, 9'd1);                        // Wrong path
    prog[14] = enc_const(3'd6, 9'd2);                        // Wrong path
    prog[15] = enc_const(3'd6, 9'h1ff);
    prog[16] = enc_br(3'b001, 9'd3);                         // BRp, NZP is N
    prog[17] = NOP;
    prog[18] = 16'h6000;                                     // Load, not supported
    prog[19] = enc_rrr(OP_ARITH, 3'd7, 3'd6, SUB_ADD, 3'd6);
  end

  lc4_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
    .o_gwe   (gwe),
    .o_rst_n (rst_n)
  );

  lc4_core i_lc4_core (
    .gwe               (gwe),
    .i_rst_n           (rst_n),
    .o_cur_pc          (cur_pc),
    .i_cur_insn        (cur_insn),
    .o_test_valid      (test_valid),
    .o_test_pc         (test_pc),
    .o_test_regfile_we (test_regfile_we),
    .o_test_wsel       (test_wsel),
    .o_test_wdata      (test_wdata),
    .o_test_nzp_we     (test_nzp_we),
    .o_test_nzp_bits   (test_nzp_bits)
  );

  lc4_checker u_checker (
    .gwe               (gwe),
    .i_rst_n           (rst_n),
    .i_test_valid      (test_valid),
    .i_test_pc         (test_pc),
    .i_test_regfile_we (test_regfile_we),
    .i_test_wsel       (test_wsel),
    .i_test_wdata      (test_wdata),
    .i_test_nzp_we     (test_nzp_we),
    .i_test_nzp_bits   (test_nzp_bits),
    .i_end             (end_req),
    .o_done            (chk_done),
    .o_reported        (chk_reported),
    .o_retired         (n_retired),
    .o_mismatches      (n_mismatch),
    .o_errors          (n_error),
    .o_missing         (n_missing)
  );

  // Memory answers each address one cycle later
  always @(posedge gwe) begin
    cur_insn <= fetch_word(cur_pc);
  end

  initial begin
    #(TIMEOUT_NS);
    timed_out = 1'b1;
    $display("Timeout: core did not retire the program within %0d ns", TIMEOUT_NS);
  end

  initial begin
    wait (chk_done || timed_out);
    @(posedge gwe);
    end_req <= 1'b1;
    wait (chk_reported);
    $display("Summary: %0d retired, %0d mismatches, %0d other errors, %0d missing, %0d timeouts",
             n_retired, n_mismatch, n_error, n_missing, timed_out);
    if (timed_out || n_mismatch != 0 || n_error != 0 || n_missing != 0) begin
      $display("tests failed");
    end else begin
      $display("all tests passed");
    end
    $finish;
  end

endmodule

// File: test/lc4_checker.sv
`timescale 1ns/10ps

module lc4_checker import lc4_pkg::*; (
  input  logic                 gwe,
  input  logic                 i_rst_n,
  input  logic                 i_test_valid,
  input  logic [WORD_W-1:0]    i_test_pc,
  input  logic                 i_test_regfile_we,
  input  logic [REG_SEL_W-1:0] i_test_wsel,
  input  logic [WORD_W-1:0]    i_test_wdata,
  input  logic                 i_test_nzp_we,
  input  logic [NZP_W-1:0]     i_test_nzp_bits,
  input  logic                 i_end,          // Run is over, list what never retired
  output logic                 o_done,         // Every expected retirement seen
  output logic                 o_reported,
  output int                   o_retired,
  output int                   o_mismatches,
  output int                   o_errors,
  output int                   o_missing
);

  localparam int EXP_LEN = 18;

  // Expected retirements in program order
  logic [WORD_W-1:0]    exp_pc     [EXP_LEN];
  logic                 exp_rf_we  [EXP_LEN];
  logic [REG_SEL_W-1:0] exp_wsel   [EXP_LEN];
  logic [WORD_W-1:0]    exp_wdata  [EXP_LEN];
  logic                 exp_nzp_we [EXP_LEN];
  logic [NZP_W-1:0]     exp_nzp    [EXP_LEN];

  int   idx      = 0;  // Next expected retirement
  int   mism     = 0;
  int   errs     = 0;
  logic reported = 1'b0;

  task automatic set_exp(input int k, input logic [15:0] pc, input logic rf_we,
                         input logic [2:0] wsel, input logic [15:0] wdata,
                         input logic nzp_we, input logic [2:0] nzp);
    exp_pc[k]     = pc;
    exp_rf_we[k]  = rf_we;
    exp_wsel[k]   = wsel;
    exp_wdata[k]  = wdata;
    exp_nzp_we[k] = nzp_we;
    exp_nzp[k]    = nzp;
  endtask

  initial begin
    set_exp(0,  16'h8200, 1'b1, 3'd1, 16'h0005, 1'b1, 3'b001);  // CONST R1,5
    set_exp(1,  16'h8201, 1'b1, 3'd2, 16'hfffd, 1'b1, 3'b100);  // CONST R2,-3
    set_exp(2,  16'h8202, 1'b1, 3'd3, 16'h0002, 1'b1, 3'b001);  // 5 + -3
    set_exp(3,  16'h8203, 1'b1, 3'd4, 16'hfffd, 1'b1, 3'b100);  // 2 - 5
    set_exp(4,  16'h8204, 1'b1, 3'd5, 16'h0019, 1'b1, 3'b001);  // 5 * 5
    set_exp(5,  16'h8205, 1'b1, 3'd6, 16'h0012, 1'b1, 3'b001);  // 25 - 7
    set_exp(6,  16'h8206, 1'b1, 3'd7, 16'h00f0, 1'b1, 3'b001);
    set_exp(7,  16'h8207, 1'b1, 3'd1, 16'h0000, 1'b1, 3'b010);  // 00f0 & 0002
    set_exp(8,  16'h8208, 1'b1, 3'd2, 16'hfffd, 1'b1, 3'b100);  // 00f0 | fffd
    set_exp(9,  16'h8209, 1'b1, 3'd3, 16'h00e9, 1'b1, 3'b001);  // 00f0 ^ 0019
    set_exp(10, 16'h820a, 1'b1, 3'd4, 16'h0008, 1'b1, 3'b001);  // 00e9 & 12
    set_exp(11, 16'h820b, 1'b1, 3'd5, 16'h0000, 1'b1, 3'b010);  // Zero ahead of BRz
    set_exp(12, 16'h820c, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000);  // BRz taken
    set_exp(13, 16'h820f, 1'b1, 3'd6, 16'hffff, 1'b1, 3'b100);  // Branch target
    set_exp(14, 16'h8210, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000);  // BRp not taken
    set_exp(15, 16'h8211, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000);  // NOP
    set_exp(16, 16'h8212, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000);  // Unsupported opcode
    set_exp(17, 16'h8213, 1'b1, 3'd7, 16'hfffe, 1'b1, 3'b100);  // -1 + -1
  end

  task automatic check_field(input string name, input logic [15:0] got,
                             input logic [15:0] want);
    if (got !== want) begin
      mism = mism + 1;
      $display("MISMATCH at %0t: retirement %0d (PC %h) %s expected %h got %h",
               $time, idx, exp_pc[idx], name, want, got);
    end
  endtask

  task automatic report_missing();
    for (int k = idx; k < EXP_LEN; k++) begin
      $display("Missing retirement: PC %h never retired", exp_pc[k]);
    end
  endtask

  // Sample on the falling edge, test ports settle after the rising edge
  always @(negedge gwe) begin
    if (i_end) begin
      if (!reported) begin
        report_missing();
        reported = 1'b1;
      end
    end else if (!i_rst_n) begin
      if (i_test_valid || i_test_regfile_we || i_test_nzp_we) begin
        errs = errs + 1;
        $display("Error at %0t: retirement or write enable active during reset", $time);
      end
    end else if (i_test_valid && idx < EXP_LEN) begin
      check_field("pc", i_test_pc, exp_pc[idx]);
      check_field("regfile_we", 16'(i_test_regfile_we), 16'(exp_rf_we[idx]));
      if (exp_rf_we[idx]) begin  // Data only matters when written
        check_field("wsel", 16'(i_test_wsel), 16'(exp_wsel[idx]));
        check_field("wdata", i_test_wdata, exp_wdata[idx]);
      end
      check_field("nzp_we", 16'(i_test_nzp_we), 16'(exp_nzp_we[idx]));
      if (exp_nzp_we[idx]) begin
        check_field("nzp_bits", 16'(i_test_nzp_bits), 16'(exp_nzp[idx]));
      end
      idx = idx + 1;
    end
  end

  assign o_done       = (idx == EXP_LEN);
  assign o_reported   = reported;
  assign o_retired    = idx;
  assign o_mismatches = mism;
  assign o_errors     = errs;
  assign o_missing    = EXP_LEN - idx;

endmodule

// File: test/lc4_clock.sv
`timescale 1ns/10ps

module lc4_clock #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 16
) (
  output logic o_gwe,
  output logic o_rst_n
);

  initial begin
    o_gwe = 1'b0;
    forever begin
      #(PERIOD_NS / 2) o_gwe = ~o_gwe;  // Free-running core clock
    end
  end

  // Reset low from time zero, released on a rising edge
  initial begin
    o_rst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge o_gwe);
    o_rst_n <= 1'b1;
  end

endmodule

// File: design/lc4_core.sv
`timescale 1ns/10ps

module lc4_core import lc4_pkg::*; #(
  parameter logic [WORD_W-1:0] RESET_PC = RESET_PC_DEF
) (
  input  logic                 gwe,
  input  logic                 i_rst_n,
  output logic [WORD_W-1:0]    o_cur_pc,           // Instruction memory address
  input  logic [WORD_W-1:0]    i_cur_insn,         // Word for last cycle's address
  output logic                 o_test_valid,
  output logic [WORD_W-1:0]    o_test_pc,
  output logic                 o_test_regfile_we,
  output logic [REG_SEL_W-1:0] o_test_wsel,
  output logic [WORD_W-1:0]    o_test_wdata,
  output logic                 o_test_nzp_we,
  output logic [NZP_W-1:0]     o_test_nzp_bits
);

  logic [WORD_W-1:0]    f_req_pc;
  logic                 f_req_valid;
  logic                 x_valid;
  logic [WORD_W-1:0]    x_pc;
  alu_op_e              x_op;
  logic [REG_SEL_W-1:0] x_wsel;
  logic                 x_regfile_we;
  logic                 x_nzp_we;
  logic [REG_SEL_W-1:0] x_rs_sel;
  logic [REG_SEL_W-1:0] x_rt_sel;
  logic [WORD_W-1:0]    x_rs_data;
  logic [WORD_W-1:0]    x_rt_data;
  logic [WORD_W-1:0]    x_imm;
  logic                 x_use_imm;
  logic [NZP_W-1:0]     x_br_mask;
  logic                 x_is_branch;
  logic                 x_flush;
  logic [WORD_W-1:0]    x_target;
  logic                 w_regfile_we;
  logic [REG_SEL_W-1:0] w_wsel;
  logic [WORD_W-1:0]    w_wdata;

  lc4_fetch #(.RESET_PC(RESET_PC)) u_fetch (
    .gwe         (gwe),
    .i_rst_n     (i_rst_n),
    .i_flush     (x_flush),
    .i_target    (x_target),
    .o_cur_pc    (o_cur_pc),
    .o_req_pc    (f_req_pc),
    .o_req_valid (f_req_valid)
  );

  lc4_decode u_decode (
    .gwe            (gwe),
    .i_rst_n        (i_rst_n),
    .i_insn         (i_cur_insn),
    .i_pc           (f_req_pc),
    .i_valid        (f_req_valid),
    .i_flush        (x_flush),
    .i_w_we         (w_regfile_we),
    .i_w_wsel       (w_wsel),
    .i_w_wdata      (w_wdata),
    .o_x_valid      (x_valid),
    .o_x_pc         (x_pc),
    .o_x_op         (x_op),
    .o_x_wsel       (x_wsel),
    .o_x_regfile_we (x_regfile_we),
    .o_x_nzp_we     (x_nzp_we),
    .o_x_rs_sel     (x_rs_sel),
    .o_x_rt_sel     (x_rt_sel),
    .o_x_rs_data    (x_rs_data),
    .o_x_rt_data    (x_rt_data),
    .o_x_imm        (x_imm),
    .o_x_use_imm    (x_use_imm),
    .o_x_br_mask    (x_br_mask),
    .o_x_is_branch  (x_is_branch)
  );

  lc4_execute u_execute (
    .gwe               (gwe),
    .i_rst_n           (i_rst_n),
    .i_x_valid         (x_valid),
    .i_x_pc            (x_pc),
    .i_x_op            (x_op),
    .i_x_wsel          (x_wsel),
    .i_x_regfile_we    (x_regfile_we),
    .i_x_nzp_we        (x_nzp_we),
    .i_x_rs_sel        (x_rs_sel),
    .i_x_rt_sel        (x_rt_sel),
    .i_x_rs_data       (x_rs_data),
    .i_x_rt_data       (x_rt_data),
    .i_x_imm           (x_imm),
    .i_x_use_imm       (x_use_imm),
    .i_x_br_mask       (x_br_mask),
    .i_x_is_branch     (x_is_branch),
    .o_flush           (x_flush),
    .o_target          (x_target),
    .o_w_we            (w_regfile_we),
    .o_w_wsel          (w_wsel),
    .o_w_wdata         (w_wdata),
    .o_test_valid      (o_test_valid),
    .o_test_pc         (o_test_pc),
    .o_test_regfile_we (o_test_regfile_we),
    .o_test_wsel       (o_test_wsel),
    .o_test_wdata      (o_test_wdata),
    .o_test_nzp_we     (o_test_nzp_we),
    .o_test_nzp_bits   (o_test_nzp_bits)
  );

endmodule

// File: design/lc4_execute.sv
`timescale 1ns/10ps

module lc4_execute import lc4_pkg::*; (
  input  logic                 gwe,
  input  logic                 i_rst_n,
  input  logic                 i_x_valid,
  input  logic [WORD_W-1:0]    i_x_pc,
  input  alu_op_e              i_x_op,
  input  logic [REG_SEL_W-1:0] i_x_wsel,
  input  logic                 i_x_regfile_we,
  input  logic                 i_x_nzp_we,
  input  logic [REG_SEL_W-1:0] i_x_rs_sel,
  input  logic [REG_SEL_W-1:0] i_x_rt_sel,
  input  logic [WORD_W-1:0]    i_x_rs_data,
  input  logic [WORD_W-1:0]    i_x_rt_data,
  input  logic [WORD_W-1:0]    i_x_imm,
  input  logic                 i_x_use_imm,
  input  logic [NZP_W-1:0]     i_x_br_mask,
  input  logic                 i_x_is_branch,
  output logic                 o_flush,            // Taken branch, redirect fetch
  output logic [WORD_W-1:0]    o_target,
  output logic                 o_w_we,             // Register file write port
  output logic [REG_SEL_W-1:0] o_w_wsel,
  output logic [WORD_W-1:0]    o_w_wdata,
  output logic                 o_test_valid,
  output logic [WORD_W-1:0]    o_test_pc,
  output logic                 o_test_regfile_we,
  output logic [REG_SEL_W-1:0] o_test_wsel,
  output logic [WORD_W-1:0]    o_test_wdata,
  output logic                 o_test_nzp_we,
  output logic [NZP_W-1:0]     o_test_nzp_bits
);

  logic [WORD_W-1:0]    rs_val;
  logic [WORD_W-1:0]    rt_val;
  logic [WORD_W-1:0]    opb;
  logic [WORD_W-1:0]    alu_res;
  logic [NZP_W-1:0]     x_nzp;
  logic [NZP_W-1:0]     br_nzp;
  logic [NZP_W-1:0]     nzp_q;       // Architectural condition codes
  logic                 w_valid;
  logic [WORD_W-1:0]    w_pc;
  logic                 w_regfile_we;
  logic [REG_SEL_W-1:0] w_wsel;
  logic [WORD_W-1:0]    w_wdata;
  logic                 w_nzp_we;
  logic [NZP_W-1:0]     w_nzp_bits;

  // Bypass from writeback, covers the back-to-back dependency
  assign rs_val = (w_regfile_we && (w_wsel == i_x_rs_sel)) ? w_wdata : i_x_rs_data;
  assign rt_val = (w_regfile_we && (w_wsel == i_x_rt_sel)) ? w_wdata : i_x_rt_data;
  assign opb    = i_x_use_imm ? i_x_imm : rt_val;

  always_comb begin
    case (i_x_op)
      ALU_ADD:   alu_res = rs_val + opb;
      ALU_MUL:   alu_res = rs_val * opb;  // Low half of the product
      ALU_SUB:   alu_res = rs_val - opb;
      ALU_AND:   alu_res = rs_val & opb;
      ALU_OR:    alu_res = rs_val | opb;
      ALU_XOR:   alu_res = rs_val ^ opb;
      ALU_CONST: alu_res = i_x_imm;
      default:   alu_res = '0;
    endcase
  end

  assign x_nzp[2] = alu_res[WORD_W-1];               // N
  assign x_nzp[1] = (alu_res == '0);                 // Z
  assign x_nzp[0] = !alu_res[WORD_W-1] && !x_nzp[1]; // P

  // NZP from writeback is newer than the register
  assign br_nzp   = w_nzp_we ? w_nzp_bits : nzp_q;
  assign o_flush  = i_x_is_branch && |(i_x_br_mask & br_nzp);
  assign o_target = i_x_pc + 16'd1 + i_x_imm;

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      w_valid      <= 1'b0;
      w_regfile_we <= 1'b0;
      w_nzp_we     <= 1'b0;
      nzp_q        <= '0;
    end else begin
      w_valid      <= i_x_valid;
      w_regfile_we <= i_x_regfile_we;
      w_nzp_we     <= i_x_nzp_we;
      if (w_nzp_we) begin
        nzp_q <= w_nzp_bits;  // Commit at writeback
      end
    end
  end

  always_ff @(posedge gwe) begin
    w_pc       <= i_x_pc;
    w_wsel     <= i_x_wsel;
    w_wdata    <= alu_res;
    w_nzp_bits <= x_nzp;
  end

  assign o_w_we    = w_regfile_we;
  assign o_w_wsel  = w_wsel;
  assign o_w_wdata = w_wdata;

  assign o_test_valid      = w_valid;
  assign o_test_pc         = w_pc;
  assign o_test_regfile_we = w_regfile_we;
  assign o_test_wsel       = w_wsel;
  assign o_test_wdata      = w_wdata;
  assign o_test_nzp_we     = w_nzp_we;
  assign o_test_nzp_bits   = w_nzp_bits;

  // Decode must never hand a live branch flag to a bubble
  a_no_flush_on_bubble : assert property (@(posedge gwe) disable iff (!i_rst_n)
    !i_x_valid |-> !o_flush);

endmodule

// File: design/lc4_decode.sv
`timescale 1ns/10ps

module lc4_decode import lc4_pkg::*; (
  input  logic                 gwe,
  input  logic                 i_rst_n,
  input  insn_u                i_insn,       // Word from instruction memory
  input  logic [WORD_W-1:0]    i_pc,
  input  logic                 i_valid,
  input  logic                 i_flush,      // Taken branch, squash this slot
  input  logic                 i_w_we,       // Writeback into the register file
  input  logic [REG_SEL_W-1:0] i_w_wsel,
  input  logic [WORD_W-1:0]    i_w_wdata,
  output logic                 o_x_valid,
  output logic [WORD_W-1:0]    o_x_pc,
  output alu_op_e              o_x_op,
  output logic [REG_SEL_W-1:0] o_x_wsel,
  output logic                 o_x_regfile_we,
  output logic                 o_x_nzp_we,
  output logic [REG_SEL_W-1:0] o_x_rs_sel,
  output logic [REG_SEL_W-1:0] o_x_rt_sel,
  output logic [WORD_W-1:0]    o_x_rs_data,
  output logic [WORD_W-1:0]    o_x_rt_data,
  output logic [WORD_W-1:0]    o_x_imm,       // Sign-extended imm5 or imm9
  output logic                 o_x_use_imm,   // Second ALU operand is o_x_imm
  output logic [NZP_W-1:0]     o_x_br_mask,
  output logic                 o_x_is_branch
);

  logic [WORD_W-1:0]    imm5_sx;
  logic [WORD_W-1:0]    imm9_sx;
  logic [WORD_W-1:0]    rs_data;
  logic [WORD_W-1:0]    rt_data;
  alu_op_e              d_op;
  logic [WORD_W-1:0]    d_imm;
  logic                 d_use_imm;
  logic                 d_writes;   // Writes both a register and NZP
  logic                 d_is_branch;

  // imm5 is sub2 followed by rt
  assign imm5_sx = {{(WORD_W-5){i_insn.alu_fmt.sub2[1]}}, i_insn.alu_fmt.sub2,
                    i_insn.alu_fmt.rt};
  assign imm9_sx = {{(WORD_W-9){i_insn.imm_fmt.imm9[8]}}, i_insn.imm_fmt.imm9};

  lc4_regfile u_regfile (
    .gwe       (gwe),
    .i_rst_n   (i_rst_n),
    .i_rs_sel  (i_insn.alu_fmt.rs),
    .i_rt_sel  (i_insn.alu_fmt.rt),
    .i_wsel    (i_w_wsel),
    .i_we      (i_w_we),
    .i_wdata   (i_w_wdata),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data)
  );

  always_comb begin
    d_op        = ALU_PASS_NONE;  // Anything unlisted retires with no writes
    d_imm       = imm5_sx;
    d_use_imm   = 1'b0;
    d_writes    = 1'b0;
    d_is_branch = 1'b0;
    case (i_insn.alu_fmt.opcode)
      OP_ARITH: begin
        d_writes = 1'b1;
        if (i_insn.alu_fmt.imm_flag) begin
          d_op      = ALU_ADD;  // ADD imm5
          d_use_imm = 1'b1;
        end else begin
          case (i_insn.alu_fmt.sub2)
            SUB_ADD: d_op = ALU_ADD;
            SUB_MUL: d_op = ALU_MUL;
            SUB_SUB: d_op = ALU_SUB;
            default: d_writes = 1'b0;  // DIV dropped
          endcase
        end
      end
      OP_LOGIC: begin
        d_writes = 1'b1;
        if (i_insn.alu_fmt.imm_flag) begin
          d_op      = ALU_AND;  // AND imm5
          d_use_imm = 1'b1;
        end else begin
          case (i_insn.alu_fmt.sub2)
            SUB_AND: d_op = ALU_AND;
            SUB_OR:  d_op = ALU_OR;
            SUB_XOR: d_op = ALU_XOR;
            default: d_writes = 1'b0;  // NOT dropped
          endcase
        end
      end
      OP_CONST: begin
        d_op     = ALU_CONST;
        d_imm    = imm9_sx;
        d_writes = 1'b1;
      end
      OP_BR: begin
        d_is_branch = 1'b1;  // Mask of zero is a NOP, never taken
        d_imm       = imm9_sx;
      end
      default: ;
    endcase
  end

  // Control half of the execute register, a bubble clears every enable
  always_ff @(posedge gwe) begin
    if (!i_rst_n || !i_valid || i_flush) begin
      o_x_valid      <= 1'b0;
      o_x_regfile_we <= 1'b0;
      o_x_nzp_we     <= 1'b0;
      o_x_is_branch  <= 1'b0;
    end else begin
      o_x_valid      <= 1'b1;
      o_x_regfile_we <= d_writes;
      o_x_nzp_we     <= d_writes;
      o_x_is_branch  <= d_is_branch;
    end
  end

  // Payload half
  always_ff @(posedge gwe) begin
    o_x_pc      <= i_pc;
    o_x_op      <= d_op;
    o_x_wsel    <= i_insn.alu_fmt.rd;  // CONST destination sits in the same bits
    o_x_rs_sel  <= i_insn.alu_fmt.rs;
    o_x_rt_sel  <= i_insn.alu_fmt.rt;
    o_x_rs_data <= rs_data;
    o_x_rt_data <= rt_data;
    o_x_imm     <= d_imm;
    o_x_use_imm <= d_use_imm;
    o_x_br_mask <= i_insn.imm_fmt.rd_nzp;
  end

  // A bubble in execute reaches the register file port with no write
  a_bubble_quiet : assert property (@(posedge gwe) disable iff (!i_rst_n)
    !o_x_valid |=> !i_w_we);

endmodule

// File: design/lc4_fetch.sv
`timescale 1ns/10ps

module lc4_fetch import lc4_pkg::*; #(
  parameter logic [WORD_W-1:0] RESET_PC = RESET_PC_DEF
) (
  input  logic              gwe,
  input  logic              i_rst_n,
  input  logic              i_flush,      // Taken branch in execute
  input  logic [WORD_W-1:0] i_target,     // Branch target from execute
  output logic [WORD_W-1:0] o_cur_pc,     // Address to instruction memory
  output logic [WORD_W-1:0] o_req_pc,     // PC of the word arriving this cycle
  output logic              o_req_valid   // Low for a killed or reset request
);

  logic [WORD_W-1:0] pc_q;
  logic [WORD_W-1:0] pc_next;

  assign pc_next  = i_flush ? i_target : pc_q + 16'd1;  // Redirect wins over sequential fetch
  assign o_cur_pc = pc_q;

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  // Track the request now in flight, memory answers one cycle later
  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      o_req_valid <= 1'b0;
    end else begin
      o_req_valid <= !i_flush;  // Word fetched under a taken branch is dropped
    end
  end

  always_ff @(posedge gwe) begin
    o_req_pc <= pc_q;  // Payload only
  end

  // Two empty slots follow a taken branch, so no redirect comes in the next two cycles
  a_flush_spacing : assert property (@(posedge gwe) disable iff (!i_rst_n)
    i_flush |=> !i_flush ##1 !i_flush);

endmodule

// File: design/lc4_regfile.sv
`timescale 1ns/10ps

module lc4_regfile import lc4_pkg::*; (
  input  logic                 gwe,
  input  logic                 i_rst_n,
  input  logic [REG_SEL_W-1:0] i_rs_sel,
  input  logic [REG_SEL_W-1:0] i_rt_sel,
  input  logic [REG_SEL_W-1:0] i_wsel,
  input  logic                 i_we,
  input  logic [WORD_W-1:0]    i_wdata,
  output logic [WORD_W-1:0]    o_rs_data,
  output logic [WORD_W-1:0]    o_rt_data
);

  logic [WORD_W-1:0] regs [2**REG_SEL_W];

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      regs <= '{default: '0};  // All registers start at zero
    end else if (i_we) begin
      regs[i_wsel] <= i_wdata;
    end
  end

  // Write-through, a same-cycle write is seen by the reader
  assign o_rs_data = (i_we && (i_wsel == i_rs_sel)) ? i_wdata : regs[i_rs_sel];
  assign o_rt_data = (i_we && (i_wsel == i_rt_sel)) ? i_wdata : regs[i_rt_sel];

endmodule

// File: design/lc4_pkg.sv
package lc4_pkg;

  localparam int WORD_W    = 16;  // Data and address width
  localparam int REG_SEL_W = 3;   // Eight registers
  localparam int NZP_W     = 3;

  localparam logic [WORD_W-1:0] RESET_PC_DEF = 16'h8200;  // First fetch address

  // Opcodes in bits 15:12
  localparam logic [3:0] OP_BR    = 4'b0000;
  localparam logic [3:0] OP_ARITH = 4'b0001;
  localparam logic [3:0] OP_LOGIC = 4'b0101;
  localparam logic [3:0] OP_CONST = 4'b1001;

  // Arithmetic sub-operations in bits 4:3
  localparam logic [1:0] SUB_ADD = 2'b00;
  localparam logic [1:0] SUB_MUL = 2'b01;
  localparam logic [1:0] SUB_SUB = 2'b10;

  // Logic sub-operations in bits 4:3, 01 is NOT and is not kept
  localparam logic [1:0] SUB_AND = 2'b00;
  localparam logic [1:0] SUB_OR  = 2'b10;
  localparam logic [1:0] SUB_XOR = 2'b11;

  // One instruction word, seen as register format or as 9-bit immediate format
  typedef union packed {
    struct packed {
      logic [3:0]           opcode;
      logic [REG_SEL_W-1:0] rd;
      logic [REG_SEL_W-1:0] rs;
      logic                 imm_flag;  // Set for the imm5 forms
      logic [1:0]           sub2;      // Upper imm5 bits when imm_flag is set
      logic [REG_SEL_W-1:0] rt;
    } alu_fmt;
    struct packed {
      logic [3:0]       opcode;
      logic [NZP_W-1:0] rd_nzp;  // CONST destination or BR condition mask
      logic [8:0]       imm9;
    } imm_fmt;
  } insn_u;

  // Operation carried from decode into execute
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_MUL,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_CONST,
    ALU_PASS_NONE  // Branch, NOP or unsupported opcode
  } alu_op_e;

endpackage
